//--- source/uart_line_pkg.sv
// Serial timing is fixed when the design is built, and both line ends assume 8N1 at cycles_per_bit clocks per bit.
`default_nettype none

package uart_line_pkg;

  // Clock cycles in one serial bit.
  // The receiver samples each bit near its middle.
  localparam int cycles_per_bit = 8;

  // Stop bits sent after the real stop bit, so that a far receiver can resync.
  localparam int extra_stop_bits = 7;

  // Data bits per byte, sent least significant first.
  localparam int data_bits = 8;

  // Start bit, eight data bits and one stop bit, then the idle tail.
  localparam int tx_bits_per_byte = 10 + extra_stop_bits;

  // Bit times of idle line that end a partial frame in the decoder.
  localparam int line_idle_bits = 2;
  localparam int line_idle_cycles = line_idle_bits * cycles_per_bit;

  // A reply is two bytes, and each one is counted with its full stop tail.
  localparam int reply_cycles = 2 * tx_bits_per_byte * cycles_per_bit;

  typedef logic [data_bits-1:0]                  uart_byte_t;
  typedef logic [$clog2(data_bits)-1:0]          bit_index_t;
  typedef logic [$clog2(cycles_per_bit)-1:0]     bit_cycle_t;
  typedef logic [$clog2(tx_bits_per_byte)-1:0]   tx_cursor_t;
  typedef logic [$clog2(line_idle_cycles+1)-1:0] idle_count_t;
  typedef logic [$clog2(reply_cycles)-1:0]       reply_count_t;

  localparam bit_cycle_t bit_cycle_max = bit_cycle_t'(cycles_per_bit - 1);
  // Start bit sample point, counted from the cycle after the edge is seen.
  // Two cycles are taken off for the synchronizer and the edge detector.
  localparam bit_cycle_t bit_cycle_mid = bit_cycle_t'(cycles_per_bit / 2 - 2);
  localparam bit_index_t bit_index_max = bit_index_t'(data_bits - 1);
  localparam tx_cursor_t tx_cursor_max = tx_cursor_t'(tx_bits_per_byte - 1);
  localparam tx_cursor_t tx_cursor_tail = tx_cursor_t'(extra_stop_bits);
  localparam idle_count_t idle_count_max = idle_count_t'(line_idle_cycles);
  localparam reply_count_t reply_count_max = reply_count_t'(reply_cycles - 1);

endpackage

`default_nettype wire

//--- source/cmd_pkg.sv
// Frames are opcode, operand A, operand B with no checksum, and only the five listed opcodes are legal.
`default_nettype none

package cmd_pkg;

  // Width of one operand and of the ALU result byte.
  localparam int operand_bits = 8;

  typedef logic [operand_bits-1:0] operand_t;
  // The ALU works one bit wider so that carry and borrow fall out of the sum.
  typedef logic [operand_bits:0]   alu_wide_t;

  typedef enum logic [operand_bits-1:0] {
    OP_ADD  = 8'h01,
    OP_SUB  = 8'h02,
    OP_AND  = 8'h03,
    OP_XOR  = 8'h04,
    OP_PASS = 8'h05
  } opcode_e;

  // One complete command as it leaves the decoder.
  typedef struct packed {
    opcode_e  opcode;
    operand_t operand_a;
    operand_t operand_b;
    logic     illegal;
  } cmd_frame_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic illegal;
    logic overrun;
  } alu_flags_t;

  typedef struct packed {
    operand_t   result;
    alu_flags_t flags;
  } exec_result_t;

  // Second reply byte, with the zero flag in bit 0.
  typedef struct packed {
    logic [3:0] reserved;
    logic       overrun;
    logic       illegal;
    logic       carry;
    logic       zero;
  } status_byte_t;

  // True for any opcode byte that names one of the ALU operations.
  function automatic logic opcode_legal(input operand_t code);
    logic legal;
    case (code)
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_PASS: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

endpackage

`default_nettype wire

//--- source/uart_rx.sv
// Receives 8N1 only, with no parity or break detection, and a low stop bit discards the byte.
`default_nettype none
`timescale 1ns/10ps

module uart_rx (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_rx,
  output uart_line_pkg::uart_byte_t o_byte,
  output logic                      o_byte_valid,
  output logic                      o_frame_err,
  output logic                      o_line_idle
);
  import uart_line_pkg::*;

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

  state_e      state;
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_prev;
  bit_cycle_t  cycle;
  bit_index_t  bit_idx;
  idle_count_t idle_count;
  logic        bit_done;

  // The line is asynchronous to clk, so it passes two flops first.
  // The third flop keeps the previous level for falling edge detection.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // After the start bit, every bit is sampled one full bit time after the last one.
  assign bit_done = (cycle == bit_cycle_max);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      cycle        <= '0;
      bit_idx      <= '0;
      o_byte_valid <= 1'b0;
      o_frame_err  <= 1'b0;
    end else begin
      o_byte_valid <= 1'b0;
      o_frame_err  <= 1'b0;
      cycle        <= bit_done ? '0 : cycle + 1'b1;
      case (state)
        IDLE: begin
          cycle <= '0;
          // Only a falling edge starts a byte, so a line stuck low after a bad stop waits.
          if (rx_prev && !rx_sync) begin
            state <= START;
          end
        end
        START: begin
          if (cycle == bit_cycle_mid) begin
            cycle   <= '0;
            bit_idx <= '0;
            // A start bit that is high again at mid-bit was a glitch.
            state   <= rx_sync ? IDLE : DATA;
          end
        end
        DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == bit_index_max) begin
              state <= STOP;
            end
          end
        end
        STOP: begin
          if (bit_done) begin
            // A good stop bit releases the byte, and a low one only reports the error.
            o_byte_valid <= rx_sync;
            o_frame_err  <= !rx_sync;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data arrives least significant bit first, so it shifts in from the top.
  always_ff @(posedge clk) begin
    if (state == DATA && bit_done) begin
      o_byte <= {rx_sync, o_byte[data_bits-1:1]};
    end
  end

  // Counts idle high cycles and fires once when the line has been quiet long enough.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_count  <= '0;
      o_line_idle <= 1'b0;
    end else begin
      o_line_idle <= 1'b0;
      if (state != IDLE || !rx_sync) begin
        idle_count <= '0;
      end else if (idle_count != idle_count_max) begin
        idle_count <= idle_count + 1'b1;
        if (idle_count == idle_count_max - 1'b1) begin
          o_line_idle <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// Sends 8N1 plus extra_stop_bits idle bits per byte, and a byte is taken on any cycle where o_cts and i_req are both high.
`default_nettype none
`timescale 1ns/10ps

module uart_tx (
  input  logic                      clk,
  input  logic                      rst_n,
  input  uart_line_pkg::uart_byte_t i_data,
  input  logic                      i_req,
  output logic                      o_serial,
  output logic                      o_cts,
  output logic                      o_idle
);
  import uart_line_pkg::*;

  // Cycles left in the current bit, counting down.
  bit_cycle_t cycle;
  // Bits left in the current byte, counting down from the start bit.
  tx_cursor_t cursor;
  // Start bit in bit 0 and the data above it.
  logic [data_bits:0] buffer;

  always_comb begin
    o_serial = buffer[0];
    // The next byte may start on the last cycle of the stop bit or anywhere in the tail.
    o_cts    = ((cursor == tx_cursor_tail) && (cycle == '0)) || (cursor < tx_cursor_tail);
    o_idle   = (cursor == '0) && (cycle == '0);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle  <= '0;
      cursor <= '0;
      buffer <= '1;
    end else begin
      if (o_cts && i_req) begin
        // New byte. The start bit goes out from the next cycle.
        cycle  <= bit_cycle_max;
        cursor <= tx_cursor_max;
        buffer <= {i_data, 1'b0};
      end else if (cycle != '0) begin
        cycle <= cycle - 1'b1;
      end else if (cursor != '0) begin
        // Next bit.
        // Ones fill in from the top and become the stop bits.
        cycle  <= bit_cycle_max;
        cursor <= cursor - 1'b1;
        buffer <= {1'b1, buffer[data_bits:1]};
      end
    end
  end

endmodule

`default_nettype wire

//--- source/cmd_decode.sv
// Takes bytes in the order opcode, operand A, operand B, and only a line idle strobe realigns a broken frame.
`default_nettype none
`timescale 1ns/10ps

module cmd_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  uart_line_pkg::uart_byte_t i_byte,
  input  logic                      i_byte_valid,
  input  logic                      i_line_idle,
  output cmd_pkg::cmd_frame_t       o_frame,
  output logic                      o_frame_valid
);
  import cmd_pkg::*;

  typedef enum logic [1:0] {OPCODE, OPERAND_A, OPERAND_B} pos_e;

  // Position of the next expected byte within the frame.
  pos_e pos;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos           <= OPCODE;
      o_frame_valid <= 1'b0;
    end else begin
      o_frame_valid <= 1'b0;
      if (i_line_idle) begin
        // A quiet line in mid-frame means the host gave up on it.
        pos <= OPCODE;
      end else if (i_byte_valid) begin
        case (pos)
          OPCODE:    pos <= OPERAND_A;
          OPERAND_A: pos <= OPERAND_B;
          OPERAND_B: begin
            pos           <= OPCODE;
            o_frame_valid <= 1'b1;
          end
          default:   pos <= OPCODE;
        endcase
      end
    end
  end

  // Each byte lands in its field as it arrives.
  // The frame is complete and stable when o_frame_valid rises.
  always_ff @(posedge clk) begin
    if (i_byte_valid) begin
      case (pos)
        OPCODE: begin
          o_frame.opcode <= opcode_e'(i_byte);
        end
        OPERAND_A: begin
          o_frame.operand_a <= i_byte;
        end
        OPERAND_B: begin
          o_frame.operand_b <= i_byte;
          // Classified once the frame is whole.
          o_frame.illegal   <= !opcode_legal(o_frame.opcode);
        end
        default: begin
          o_frame.illegal <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/cmd_execute.sv
// Eight-bit ALU with one cycle of latency, and an illegal frame always gives a zero result.
`default_nettype none
`timescale 1ns/10ps

module cmd_execute (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cmd_pkg::cmd_frame_t   i_frame,
  input  logic                  i_frame_valid,
  output cmd_pkg::exec_result_t o_result,
  output logic                  o_result_valid
);
  import cmd_pkg::*;

  alu_wide_t alu;

  // The top bit is the ADD carry, or the SUB borrow when operand A is below operand B.
  // The logic operations never set it.
  always_comb begin
    case (i_frame.opcode)
      OP_ADD:  alu = {1'b0, i_frame.operand_a} + {1'b0, i_frame.operand_b};
      OP_SUB:  alu = {1'b0, i_frame.operand_a} - {1'b0, i_frame.operand_b};
      OP_AND:  alu = {1'b0, i_frame.operand_a & i_frame.operand_b};
      OP_XOR:  alu = {1'b0, i_frame.operand_a ^ i_frame.operand_b};
      OP_PASS: alu = {1'b0, i_frame.operand_a};
      default: alu = '0;
    endcase
    if (i_frame.illegal) begin
      alu = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_frame_valid) begin
      o_result.result        <= alu[operand_bits-1:0];
      o_result.flags.carry   <= alu[operand_bits];
      o_result.flags.zero    <= (alu[operand_bits-1:0] == '0);
      o_result.flags.illegal <= i_frame.illegal;
      // Overrun is only known in the reply stage.
      o_result.flags.overrun <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_result_valid <= 1'b0;
    end else begin
      o_result_valid <= i_frame_valid;
    end
  end

endmodule

`default_nettype wire

//--- source/resp_result.sv
// Holds one reply only, for its full two-byte line time, and drops any result that arrives in that window.
`default_nettype none
`timescale 1ns/10ps

module resp_result (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cmd_pkg::exec_result_t     i_result,
  input  logic                      i_result_valid,
  input  logic                      i_cts,
  output uart_line_pkg::uart_byte_t o_tx_data,
  output logic                      o_tx_req,
  output logic                      o_overrun
);
  import uart_line_pkg::*;
  import cmd_pkg::*;

  typedef enum logic [1:0] {IDLE, SEND_RESULT, SEND_STATUS} state_e;

  state_e       state;
  exec_result_t held;
  status_byte_t status;
  reply_count_t reply_left;
  logic         status_sent;
  logic         overrun_sticky;
  logic         busy;
  logic         accept;

  assign busy   = (state != IDLE);
  // The transmitter takes the byte on any cycle where both strobes are high.
  assign accept = o_tx_req && i_cts;

  always_comb begin
    status.reserved = '0;
    status.overrun  = held.flags.overrun | overrun_sticky;
    status.illegal  = held.flags.illegal;
    status.carry    = held.flags.carry;
    status.zero     = held.flags.zero;
  end

  assign o_tx_req  = (state == SEND_RESULT) || (state == SEND_STATUS && !status_sent);
  assign o_tx_data = (state == SEND_RESULT) ? held.result : status;

  always_ff @(posedge clk) begin
    if (i_result_valid && !busy) begin
      held <= i_result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      reply_left     <= '0;
      status_sent    <= 1'b0;
      overrun_sticky <= 1'b0;
      o_overrun      <= 1'b0;
    end else begin
      o_overrun <= i_result_valid && busy;
      // A new drop wins over the clear, since the accepted status did not carry it.
      if (i_result_valid && busy) begin
        overrun_sticky <= 1'b1;
      end else if (state == SEND_STATUS && accept) begin
        overrun_sticky <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (i_result_valid) begin
            state <= SEND_RESULT;
          end
        end
        SEND_RESULT: begin
          if (accept) begin
            state       <= SEND_STATUS;
            reply_left  <= reply_count_max;
            status_sent <= 1'b0;
          end
        end
        SEND_STATUS: begin
          // Stays busy until both bytes and their stop tails have had their time.
          if (accept) begin
            status_sent <= 1'b1;
          end
          if (reply_left == '0) begin
            state <= IDLE;
          end else begin
            reply_left <= reply_left - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/uart_cmd_top.sv
// One serial port in and one out, and a single reply in flight at a time.
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_top (
  input  logic clk,
  input  logic rst_n,
  input  logic i_rx,
  output logic o_tx,
  output logic o_tx_idle,
  output logic o_frame_err,
  output logic o_overrun
);
  import uart_line_pkg::*;
  import cmd_pkg::*;

  uart_byte_t   rx_byte;
  logic         rx_byte_valid;
  logic         rx_line_idle;
  cmd_frame_t   frame;
  logic         frame_valid;
  exec_result_t result;
  logic         result_valid;
  uart_byte_t   tx_data;
  logic         tx_req;
  logic         tx_cts;

  // Line to bytes.
  uart_rx u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_rx         (i_rx),
    .o_byte       (rx_byte),
    .o_byte_valid (rx_byte_valid),
    .o_frame_err  (o_frame_err),
    .o_line_idle  (rx_line_idle)
  );

  // Bytes to frames.
  cmd_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_byte        (rx_byte),
    .i_byte_valid  (rx_byte_valid),
    .i_line_idle   (rx_line_idle),
    .o_frame       (frame),
    .o_frame_valid (frame_valid)
  );

  cmd_execute u_execute (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_frame        (frame),
    .i_frame_valid  (frame_valid),
    .o_result       (result),
    .o_result_valid (result_valid)
  );

  // The reply stage paces itself on the transmitter's clear-to-send.
  resp_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_result       (result),
    .i_result_valid (result_valid),
    .i_cts          (tx_cts),
    .o_tx_data      (tx_data),
    .o_tx_req       (tx_req),
    .o_overrun      (o_overrun)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_data   (tx_data),
    .i_req    (tx_req),
    .o_serial (o_tx),
    .o_cts    (tx_cts),
    .o_idle   (o_tx_idle)
  );

endmodule

`default_nettype wire

//--- verif/uart_cmd_sva.sv
// Bound into uart_cmd_top, and it sees only the reply strobes and the transmitter line, not the receiver.
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_sva (
  input logic clk,
  input logic rst_n,
  input logic i_tx_req,
  input logic i_tx_cts,
  input logic i_serial,
  input logic i_tx_idle,
  input logic i_overrun
);

  // Number of assertion failures seen so far.
  int unsigned fail_count = 0;

  // A byte request stays up until the transmitter is clear to take it.
  req_held_until_accepted: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_tx_req && !i_tx_cts |=> i_tx_req
  ) else begin
    $error("Reply request fell before the transmitter accepted the byte");
    fail_count++;
  end

  // An idle transmitter holds the line at the mark level.
  line_high_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_tx_idle |-> i_serial
  ) else begin
    $error("Serial line was low while the transmitter reported idle");
    fail_count++;
  end

  // Each dropped result gives exactly one cycle of overrun.
  overrun_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_overrun |=> !i_overrun
  ) else begin
    $error("Overrun strobe stayed high for more than one cycle");
    fail_count++;
  end

endmodule

// The top is where the reply stage and the transmitter strobes meet.
bind uart_cmd_top uart_cmd_sva sva_checks (
  .clk       (clk),
  .rst_n     (rst_n),
  .i_tx_req  (tx_req),
  .i_tx_cts  (tx_cts),
  .i_serial  (o_tx),
  .i_tx_idle (o_tx_idle),
  .i_overrun (o_overrun)
);

`default_nettype wire

//--- verif/uart_cmd_tb.sv
// Checks replies against its own ALU model, assumes the package bit time, and waits for each reply in turn.
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_tb;
  import uart_line_pkg::*;

  localparam int clk_period    = 100;
  localparam int reset_cycles  = 4;
  localparam int random_frames = 30;
  // About 50 frames in all, each one 240 cycles on the line plus a 160 cycle reply.
  localparam int test_frames   = 50;
  localparam int frame_cycles  = 500;
  localparam int timeout_cycles = test_frames * frame_cycles;

  // Opcode values as the host sends them.
  localparam logic [7:0] op_add  = 8'h01;
  localparam logic [7:0] op_sub  = 8'h02;
  localparam logic [7:0] op_and  = 8'h03;
  localparam logic [7:0] op_xor  = 8'h04;
  localparam logic [7:0] op_pass = 8'h05;

  logic clk = 1'b0;
  logic rst_n;
  logic i_rx;
  logic o_tx;
  logic o_tx_idle;
  logic o_frame_err;
  logic o_overrun;

  integer      seed;
  logic [7:0]  reply_q[$];
  int unsigned frame_err_count = 0;
  int unsigned overrun_count = 0;
  int unsigned cycle_count = 0;

  always #(clk_period / 2) clk = ~clk;

  uart_cmd_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_rx        (i_rx),
    .o_tx        (o_tx),
    .o_tx_idle   (o_tx_idle),
    .o_frame_err (o_frame_err),
    .o_overrun   (o_overrun)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
    fail_run($sformatf("Mismatch in %s: expected 0x%02h, actual 0x%02h",
                       name, expected, actual));
  endtask

  // Expected reply as {result, status}, straight from the opcode rules.
  function automatic logic [15:0] model_reply(input logic [7:0] op, input logic [7:0] a,
                                              input logic [7:0] b, input logic ovr);
    logic [8:0] wide;
    logic       illegal;
    logic       carry;
    illegal = 1'b0;
    carry   = 1'b0;
    case (op)
      op_add: begin
        wide  = {1'b0, a} + {1'b0, b};
        carry = wide[8];
      end
      op_sub: begin
        wide  = {1'b0, a} - {1'b0, b};
        carry = (a < b);
      end
      op_and:  wide = {1'b0, a & b};
      op_xor:  wide = {1'b0, a ^ b};
      op_pass: wide = {1'b0, a};
      default: begin
        wide    = '0;
        illegal = 1'b1;
      end
    endcase
    return {wide[7:0], 4'h0, ovr, illegal, carry, (wide[7:0] == 8'h00)};
  endfunction

  // One byte on the line, least significant bit first, then a high gap.
  // Called on a falling edge and returns on one.
  task automatic send_byte(input logic [7:0] data, input logic stop_level, input int gap_bits);
    int i;
    i_rx = 1'b0;
    repeat (cycles_per_bit) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      i_rx = data[i];
      repeat (cycles_per_bit) @(negedge clk);
    end
    i_rx = stop_level;
    repeat (cycles_per_bit) @(negedge clk);
    i_rx = 1'b1;
    repeat (gap_bits * cycles_per_bit) @(negedge clk);
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b);
    send_byte(op, 1'b1, 0);
    send_byte(a, 1'b1, 0);
    send_byte(b, 1'b1, 0);
  endtask

  // Waits for both reply bytes; the cycle counter bounds the wait.
  task automatic check_reply(input string name, input logic [15:0] expected);
    logic [7:0] res;
    logic [7:0] stat;
    while (reply_q.size() < 2) begin
      @(negedge clk);
    end
    res  = reply_q.pop_front();
    stat = reply_q.pop_front();
    assert (res == expected[15:8]) else report_mismatch({name, " result"}, expected[15:8], res);
    assert (stat == expected[7:0]) else report_mismatch({name, " status"}, expected[7:0], stat);
  endtask

  task automatic run_frame(input string name, input logic [7:0] op, input logic [7:0] a,
                           input logic [7:0] b, input logic ovr);
    send_frame(op, a, b);
    check_reply(name, model_reply(op, a, b, ovr));
  endtask

  // Reply capture. Start bit is seen within its first cycle, so 4 more cycles lands mid-bit.
  always begin : capture_reply
    logic [7:0] data;
    int         i;
    @(negedge clk);
    if (rst_n === 1'b1 && o_tx === 1'b0) begin
      repeat (cycles_per_bit / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
        repeat (cycles_per_bit) @(negedge clk);
        data[i] = o_tx;
      end
      repeat (cycles_per_bit) @(negedge clk);
      assert (o_tx === 1'b1) else fail_run("Reply byte was sent with a low stop bit");
      reply_q.push_back(data);
    end
  end

  // Strobes are counted where they are stable, half a cycle after they change.
  always @(negedge clk) begin
    if (o_frame_err === 1'b1) begin
      frame_err_count++;
    end
    if (o_overrun === 1'b1) begin
      overrun_count++;
    end
    if (DUT.sva_checks.fail_count != 0) begin
      fail_run("A bound assertion on the reply path failed");
    end
  end

  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("Timeout: no reply came within %0d cycles", timeout_cycles));
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [7:0]  op;
    logic [7:0]  a;
    logic [7:0]  b;
    int          n;
    seed  = 32'hfc6364b0;
    rst_n = 1'b0;
    i_rx  = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    assert (o_tx === 1'b1 && o_tx_idle === 1'b1)
      else fail_run("Serial output was not idle after reset");

    // Each opcode, with the carry, borrow and zero corners.
    run_frame("add plain", op_add, 8'h12, 8'h34, 1'b0);
    run_frame("add carry", op_add, 8'hf0, 8'h20, 1'b0);
    run_frame("add carry zero", op_add, 8'h80, 8'h80, 1'b0);
    run_frame("sub plain", op_sub, 8'h50, 8'h20, 1'b0);
    run_frame("sub borrow", op_sub, 8'h10, 8'h20, 1'b0);
    run_frame("sub zero", op_sub, 8'h33, 8'h33, 1'b0);
    run_frame("and zero", op_and, 8'hf0, 8'h0f, 1'b0);
    run_frame("and plain", op_and, 8'haa, 8'h6c, 1'b0);
    run_frame("xor plain", op_xor, 8'h5a, 8'hff, 1'b0);
    run_frame("pass plain", op_pass, 8'h7e, 8'h11, 1'b0);
    run_frame("pass zero", op_pass, 8'h00, 8'hff, 1'b0);

    for (n = 0; n < random_frames; n++) begin
      rnd = $random(seed);
      op  = op_add + 8'(rnd % 5);
      a   = 8'($random(seed));
      b   = 8'($random(seed));
      run_frame($sformatf("random %0d", n), op, a, b, 1'b0);
    end

    run_frame("illegal 00", 8'h00, 8'h55, 8'haa, 1'b0);
    run_frame("illegal 06", 8'h06, 8'h01, 8'h02, 1'b0);
    run_frame("illegal ff", 8'hff, 8'hff, 8'hff, 1'b0);

    // Operand B with a low stop bit is lost, and the idle gap puts the decoder back on opcode.
    send_byte(op_add, 1'b1, 0);
    send_byte(8'h22, 1'b1, 0);
    send_byte(8'h33, 1'b0, 4);
    assert (frame_err_count == 1) else fail_run("Low stop bit gave no framing error");
    // A reply to the broken frame would already be on the line by now.
    assert (reply_q.size() == 0 && o_tx_idle === 1'b1)
      else fail_run("Broken frame produced a reply");
    run_frame("resync", op_xor, 8'h3c, 8'h81, 1'b0);

    // The second frame lands while the first reply is still busy.
    send_frame(op_add, 8'h01, 8'h02);
    send_frame(op_xor, 8'h0f, 8'hf0);
    while (overrun_count == 0) begin
      @(negedge clk);
    end
    check_reply("overrun first", model_reply(op_add, 8'h01, 8'h02, 1'b0));
    // A reply to the dropped frame would start within one full reply time.
    repeat (reply_cycles) @(negedge clk);
    assert (reply_q.size() == 0 && o_tx_idle === 1'b1)
      else fail_run("Dropped frame produced a reply");
    run_frame("overrun flagged", op_sub, 8'h09, 8'h04, 1'b1);
    run_frame("overrun cleared", op_and, 8'h0f, 8'h3c, 1'b0);
    assert (overrun_count == 1) else fail_run("Overrun strobe count was not one");

    if (DUT.sva_checks.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("A bound assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- build.f
source/uart_line_pkg.sv
source/cmd_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/resp_result.sv
source/uart_cmd_top.sv
verif/uart_cmd_sva.sv
verif/uart_cmd_tb.sv
